// ==== Makefile ====
# Verilator build and run of the system control unit testbench

VERILATOR ?= verilator
TOP       ?= scu_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, search for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/scu_csr_file.sv ====
// CSR stage of the control unit: decodes scan accesses and holds CONTROL, MODE and STICKY
`timescale 1ns/1ps
`default_nettype none

module scu_csr_file (
    input  wire logic              clk,
    input  wire logic              pwrup_rst_n_sync,
    input  wire logic              upd_i,
    input  scu_pkg::scu_dr_s       dr_i,
    input  scu_pkg::scu_status_s   status_i,
    output scu_pkg::scu_data_t     wdata_o,
    output scu_pkg::scu_ctrl_s     ctrl_o,
    output scu_pkg::scu_mode_s     mode_o
);

    import scu_pkg::*;

    logic        ctrl_we;
    logic        mode_we;
    logic        sticky_we;
    scu_data_t   rdata;
    scu_ctrl_s   ctrl_ff;
    scu_mode_s   mode_ff;
    scu_status_s sticky_ff;
    scu_status_s status_dly_ff;
    scu_status_s status_rise;

    // ------------------------------
    // Write decode
    // ------------------------------

    always_comb begin
        ctrl_we   = 1'b0;
        mode_we   = 1'b0;
        sticky_we = 1'b0;
        // READ never writes
        if (upd_i && (dr_i.op != SCU_OP_READ)) begin
            case (dr_i.addr)
                SCU_ADDR_CONTROL: ctrl_we = 1'b1;
                SCU_ADDR_MODE:    mode_we = 1'b1;
                // STICKY only clears through CLRBITS
                SCU_ADDR_STICKY:  sticky_we = (dr_i.op == SCU_OP_CLRBITS);
                default:          ;
            endcase
        end
    end

    // ------------------------------
    // Read mux and RMW data
    // ------------------------------

    always_comb begin
        case (dr_i.addr)
            SCU_ADDR_CONTROL: rdata = scu_data_t'(ctrl_ff);
            SCU_ADDR_MODE:    rdata = scu_data_t'(mode_ff);
            SCU_ADDR_STATUS:  rdata = scu_data_t'(status_i);
            SCU_ADDR_STICKY:  rdata = scu_data_t'(sticky_ff);
            default:          rdata = '0;
        endcase
    end

    // Result goes both to the registers and back to the shadow
    always_comb begin
        wdata_o = '0;
        if (upd_i) begin
            case (dr_i.op)
                SCU_OP_READ:    wdata_o = rdata;
                SCU_OP_WRITE:   wdata_o = dr_i.data;
                SCU_OP_SETBITS: wdata_o = rdata | dr_i.data;
                SCU_OP_CLRBITS: wdata_o = rdata & ~dr_i.data;
                default:        wdata_o = '0;
            endcase
        end
    end

    // ------------------------------
    // CONTROL and MODE
    // ------------------------------

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            ctrl_ff <= '0;
        end else if (ctrl_we) begin
            ctrl_ff <= scu_ctrl_s'(wdata_o);
        end
    end

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            mode_ff <= '0;
        end else if (mode_we) begin
            mode_ff <= scu_mode_s'(wdata_o);
        end
    end

    assign ctrl_o = ctrl_ff;
    assign mode_o = mode_ff;

    // ------------------------------
    // STATUS edges and STICKY
    // ------------------------------

    // All resets are asserted under power-up reset
    // so the delayed copy starts high and no edge is seen at release
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            status_dly_ff <= '1;
        end else begin
            status_dly_ff <= status_i;
        end
    end

    assign status_rise = status_i & ~status_dly_ff;

    // Per bit, a new assertion beats a clear in the same cycle
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sticky_ff <= '0;
        end else begin
            for (int i = 0; i < $bits(scu_status_s); i++) begin
                if (status_rise[i]) begin
                    sticky_ff[i] <= 1'b1;
                end else if (sticky_we) begin
                    sticky_ff[i] <= wdata_o[i];
                end
            end
        end
    end

endmodule : scu_csr_file

`default_nettype wire

// ==== logic/scu_pkg.sv ====
// Shared types for the system control unit: scan layout, opcodes, addresses and CSR structs
package scu_pkg;

    // ------------------------------
    // Scan data register layout
    // ------------------------------

    // Register data width
    localparam int SCU_DATA_W = 4;

    // Default depth of the status synchronizers
    localparam int unsigned SCU_SYNC_STAGES_DEF = 2;

    typedef logic [SCU_DATA_W-1:0] scu_data_t;

    // Scan opcodes
    typedef enum logic [1:0] {
        SCU_OP_READ    = 2'd0,
        SCU_OP_WRITE   = 2'd1,
        SCU_OP_SETBITS = 2'd2,
        SCU_OP_CLRBITS = 2'd3
    } scu_op_e;

    // CSR addresses
    typedef enum logic [1:0] {
        SCU_ADDR_CONTROL = 2'd0,
        SCU_ADDR_MODE    = 2'd1,
        SCU_ADDR_STATUS  = 2'd2,
        SCU_ADDR_STICKY  = 2'd3
    } scu_addr_e;

    // Data sits in the LSBs so it leaves the chain first
    typedef struct packed {
        scu_op_e   op;
        scu_addr_e addr;
        scu_data_t data;
    } scu_dr_s;

    // ------------------------------
    // CSR layouts
    // ------------------------------

    // Software reset requests, upper bits kept as written
    typedef struct packed {
        logic [1:0] rsrv;
        logic       core_reset;
        logic       sys_reset;
    } scu_ctrl_s;

    // DM and HDU reset behavior selects
    typedef struct packed {
        logic [1:0] rsrv;
        logic       hdu_rst_bhv;
        logic       dm_rst_bhv;
    } scu_mode_s;

    // Live reset levels, 1 while asserted
    // Same layout is reused for STICKY
    typedef struct packed {
        logic hdu_reset;
        logic dm_reset;
        logic core_reset;
        logic sys_reset;
    } scu_status_s;

endpackage : scu_pkg

// ==== logic/scu_reset_gen.sv ====
// Reset stage of the control unit: builds sys, core, DM and HDU resets, qualifiers and statuses
`timescale 1ns/1ps
`default_nettype none

module scu_reset_gen #(
    parameter int unsigned SYNC_STAGES = scu_pkg::SCU_SYNC_STAGES_DEF
) (
    input  wire logic              clk,
    input  wire logic              pwrup_rst_n_sync,
    input  wire logic              rst_n_i,
    input  wire logic              cpu_rst_n_i,
    input  wire logic              ndm_rst_n_i,
    input  wire logic              hart_rst_n_i,
    input  scu_pkg::scu_ctrl_s     ctrl_i,
    input  scu_pkg::scu_mode_s     mode_i,
    output logic                   sys_rst_n_o,
    output logic                   core_rst_n_o,
    output logic                   dm_rst_n_o,
    output logic                   hdu_rst_n_o,
    output logic                   sys_rdc_qlfy_o,
    output logic                   core_rdc_qlfy_o,
    output logic                   hdu_rdc_qlfy_o,
    output scu_pkg::scu_status_s   status_o,
    output logic                   sys_rst_status_o,
    output logic                   core_rst_status_o
);

    logic                        sys_in;
    logic                        core_in;
    logic                        hdu_in;
    logic                        dm_in;
    // Per stage: bit 0 sys, bit 1 core
    logic [SYNC_STAGES-1:0][1:0] sts_sync_n;

    // ------------------------------
    // Reset requests
    // ------------------------------

    assign sys_in  = ~ctrl_i.sys_reset & ndm_rst_n_i & rst_n_i;
    assign core_in = sys_in & hart_rst_n_i & cpu_rst_n_i & ~ctrl_i.core_reset;
    // HDU can be kept out of core resets
    assign hdu_in  = mode_i.hdu_rst_bhv | core_in;
    // DM follows the software system reset only when enabled
    assign dm_in   = ~mode_i.dm_rst_bhv | ~ctrl_i.sys_reset;

    // ------------------------------
    // Qualified resets
    // ------------------------------

    scu_reset_qlfy_cell i_sys_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_req_n_i      (sys_in),
        .rst_n_o          (sys_rst_n_o),
        .qlfy_n_o         (sys_rdc_qlfy_o)
    );

    scu_reset_qlfy_cell i_core_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_req_n_i      (core_in),
        .rst_n_o          (core_rst_n_o),
        .qlfy_n_o         (core_rdc_qlfy_o)
    );

    scu_reset_qlfy_cell i_hdu_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_req_n_i      (hdu_in),
        .rst_n_o          (hdu_rst_n_o),
        .qlfy_n_o         (hdu_rdc_qlfy_o)
    );

    // DM reset, single flop, no qualifier
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            dm_rst_n_o <= 1'b0;
        end else begin
            dm_rst_n_o <= dm_in;
        end
    end

    // ------------------------------
    // Status
    // ------------------------------

    // Live levels straight from the reset flops
    assign status_o.sys_reset  = ~sys_rst_n_o;
    assign status_o.core_reset = ~core_rst_n_o;
    assign status_o.dm_reset   = ~dm_rst_n_o;
    assign status_o.hdu_reset  = ~hdu_rst_n_o;

    // Sys and core statuses share one chain
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sts_sync_n <= '0;
        end else begin
            sts_sync_n[0] <= {core_rst_n_o, sys_rst_n_o};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sts_sync_n[i] <= sts_sync_n[i-1];
            end
        end
    end

    assign sys_rst_status_o  = ~sts_sync_n[SYNC_STAGES-1][0];
    assign core_rst_status_o = ~sts_sync_n[SYNC_STAGES-1][1];

endmodule : scu_reset_gen

`default_nettype wire

// ==== logic/scu_reset_qlfy_cell.sv ====
// Reset cell that turns one synchronous reset request into a reset output and its RDC qualifier
`timescale 1ns/1ps
`default_nettype none

module scu_reset_qlfy_cell (
    input  wire logic clk,
    input  wire logic pwrup_rst_n_sync,
    input  wire logic rst_req_n_i,
    output logic      rst_n_o,
    output logic      qlfy_n_o
);

    logic rst_n_ff;
    logic qlfy_n_ff;

    // ------------------------------
    // Ordering flops
    // ------------------------------

    // Assert: qualifier drops first, reset follows one cycle later
    // Release: reset rises first, qualifier follows one cycle later
    // Both held low while power-up reset is active

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            qlfy_n_ff <= 1'b0;
        end else begin
            // Rises only once the reset is already released
            qlfy_n_ff <= rst_req_n_i & rst_n_ff;
        end
    end

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            rst_n_ff <= 1'b0;
        end else begin
            // Falls only after the qualifier has gone low
            rst_n_ff <= rst_req_n_i | qlfy_n_ff;
        end
    end

    assign rst_n_o  = rst_n_ff;
    assign qlfy_n_o = qlfy_n_ff;

endmodule : scu_reset_qlfy_cell

`default_nettype wire

// ==== logic/scu_scan_chain.sv ====
// Scan-chain front end of the control unit: decodes the chain, shifts data, returns CSR results
`timescale 1ns/1ps
`default_nettype none

module scu_scan_chain (
    input  wire logic              clk,
    input  wire logic              pwrup_rst_n_sync,
    input  wire logic              ch_sel_i,
    input  wire logic              ch_id_i,
    input  wire logic              ch_capture_i,
    input  wire logic              ch_shift_i,
    input  wire logic              ch_update_i,
    input  wire logic              ch_tdi_i,
    input  scu_pkg::scu_data_t     wdata_i,
    output logic                   ch_tdo_o,
    output logic                   upd_o,
    output scu_pkg::scu_dr_s       dr_o
);

    import scu_pkg::*;

    logic    chain_hit;
    logic    cap_req;
    logic    shft_req;
    scu_dr_s shift_ff;
    scu_dr_s shift_next;
    scu_dr_s shadow_ff;

    // ------------------------------
    // Chain decode
    // ------------------------------

    // Only chain 0 belongs to this unit
    assign chain_hit = ch_sel_i & ~ch_id_i;
    assign cap_req   = chain_hit & ch_capture_i;
    assign shft_req  = chain_hit & ch_shift_i;
    assign upd_o     = chain_hit & ch_update_i;

    // ------------------------------
    // Shift register
    // ------------------------------

    // Capture has priority over shift
    always_comb begin
        shift_next = shift_ff;
        if (cap_req) begin
            shift_next = shadow_ff;
        end else if (shft_req) begin
            // TDI enters at the MSB
            shift_next = {ch_tdi_i, shift_ff[$bits(scu_dr_s)-1:1]};
        end
    end

    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_ff <= '0;
        end else begin
            shift_ff <= shift_next;
        end
    end

    // ------------------------------
    // Shadow register
    // ------------------------------

    // Op and address kept, data replaced by the CSR answer
    always_ff @(posedge clk, negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_ff <= '0;
        end else if (upd_o) begin
            shadow_ff.op   <= shift_ff.op;
            shadow_ff.addr <= shift_ff.addr;
            shadow_ff.data <= wdata_i;
        end
    end

    // Scan word seen by the register file on update
    assign dr_o     = shift_ff;
    assign ch_tdo_o = shift_ff[0];

endmodule : scu_scan_chain

`default_nettype wire

// ==== logic/scu_top.sv ====
// Top level of the system control unit: scan chain, CSR file and reset generator
`timescale 1ns/1ps
`default_nettype none

module scu_top #(
    parameter int unsigned SYNC_STAGES = scu_pkg::SCU_SYNC_STAGES_DEF
) (
    input  wire logic clk,
    input  wire logic pwrup_rst_n_sync,
    input  wire logic rst_n_i,
    input  wire logic cpu_rst_n_i,
    input  wire logic ndm_rst_n_i,
    input  wire logic hart_rst_n_i,
    input  wire logic ch_sel_i,
    input  wire logic ch_id_i,
    input  wire logic ch_capture_i,
    input  wire logic ch_shift_i,
    input  wire logic ch_update_i,
    input  wire logic ch_tdi_i,
    output logic      ch_tdo_o,
    output logic      sys_rst_n_o,
    output logic      core_rst_n_o,
    output logic      dm_rst_n_o,
    output logic      hdu_rst_n_o,
    output logic      sys_rst_status_o,
    output logic      core_rst_status_o,
    output logic      sys_rdc_qlfy_o,
    output logic      core_rdc_qlfy_o,
    output logic      hdu_rdc_qlfy_o
);

    import scu_pkg::*;

    // Scan chain to CSR file
    logic        upd;
    scu_dr_s     dr;
    scu_data_t   wdata;
    // CSR file to reset generator and back
    scu_ctrl_s   ctrl;
    scu_mode_s   mode;
    scu_status_s status;

    // ------------------------------
    // Stages
    // ------------------------------

    scu_scan_chain i_scan_chain (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_id_i          (ch_id_i),
        .ch_capture_i     (ch_capture_i),
        .ch_shift_i       (ch_shift_i),
        .ch_update_i      (ch_update_i),
        .ch_tdi_i         (ch_tdi_i),
        .wdata_i          (wdata),
        .ch_tdo_o         (ch_tdo_o),
        .upd_o            (upd),
        .dr_o             (dr)
    );

    scu_csr_file i_csr_file (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .upd_i            (upd),
        .dr_i             (dr),
        .status_i         (status),
        .wdata_o          (wdata),
        .ctrl_o           (ctrl),
        .mode_o           (mode)
    );

    scu_reset_gen #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_reset_gen (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .cpu_rst_n_i       (cpu_rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .ctrl_i            (ctrl),
        .mode_i            (mode),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu_rdc_qlfy_o    (hdu_rdc_qlfy_o),
        .status_o          (status),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o)
    );

endmodule : scu_top

`default_nettype wire

// ==== sim.f ====
+incdir+sim
logic/scu_pkg.sv
logic/scu_scan_chain.sv
logic/scu_csr_file.sv
logic/scu_reset_qlfy_cell.sv
logic/scu_reset_gen.sv
logic/scu_top.sv
sim/scu_tb.sv

// ==== sim/scu_tb_tasks.svh ====
// Scan-chain access, output waits and checking tasks, included inside the control unit testbench
`ifndef SCU_TB_TASKS_SVH
`define SCU_TB_TASKS_SVH

// ------------------------------
// Checks
// ------------------------------

task automatic check_data(input string test, input scu_data_t exp, input scu_data_t act);
    check_cnt++;
    data_ok: assert (act === exp) else begin
        err_cnt++;
        $display("ERR %s: expected %h, actual %h", test, exp, act);
    end
endtask

task automatic check_count(input string test, input int exp, input int act);
    check_cnt++;
    count_ok: assert (act == exp) else begin
        err_cnt++;
        $display("ERR %s: expected %0d, actual %0d", test, exp, act);
    end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
    check_cnt++;
    bit_ok: assert (act === exp) else begin
        err_cnt++;
        $display("ERR %s: expected %b, actual %b", test, exp, act);
    end
endtask

// ------------------------------
// Output waits
// ------------------------------

function automatic logic read_output(input out_e sel);
    case (sel)
        OUT_SYS_RST:   return sys_rst_n_o;
        OUT_CORE_RST:  return core_rst_n_o;
        OUT_DM_RST:    return dm_rst_n_o;
        OUT_HDU_RST:   return hdu_rst_n_o;
        OUT_SYS_QLFY:  return sys_rdc_qlfy_o;
        OUT_CORE_QLFY: return core_rdc_qlfy_o;
        OUT_HDU_QLFY:  return hdu_rdc_qlfy_o;
        OUT_SYS_STS:   return sys_rst_status_o;
        default:       return core_rst_status_o;
    endcase
endfunction

// Cycles counted from the call, sampled 1 ns after each edge
task automatic wait_level(input out_e sel, input logic level, input int limit, output int cycles);
    cycles = 0;
    while ((read_output(sel) !== level) && (cycles < limit)) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (read_output(sel) !== level) begin
        timeout_cnt++;
        $display("Timeout: %s did not reach %b within %0d cycles", sel.name(), level, limit);
    end
endtask

task automatic idle(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

// ------------------------------
// Scan chain
// ------------------------------

// Capture, 8 shifts LSB first, optional update; TDO collected before each shift
task automatic shift_dr(input scu_dr_s din, input logic do_update, output scu_dr_s dout);
    dout = '0;
    @(posedge clk);
    #1;
    ch_capture_i = 1'b1;
    @(posedge clk);
    #1;
    ch_capture_i = 1'b0;
    for (int i = 0; i < $bits(scu_dr_s); i++) begin
        dout[i]    = ch_tdo_o;
        ch_shift_i = 1'b1;
        ch_tdi_i   = din[i];
        @(posedge clk);
        #1;
    end
    ch_shift_i  = 1'b0;
    ch_tdi_i    = 1'b0;
    ch_update_i = do_update;
    // Registers take the value on this edge
    @(posedge clk);
    #1;
    ch_update_i = 1'b0;
endtask

task automatic scan_op(input scu_op_e op, input scu_addr_e addr, input scu_data_t data);
    scu_dr_s word;
    scu_dr_s unused_out;
    word.op   = op;
    word.addr = addr;
    word.data = data;
    shift_dr(word, 1'b1, unused_out);
endtask

// READ leaves the answer in the shadow, next capture brings it out
task automatic scan_read(input scu_addr_e addr, output scu_data_t data);
    scu_dr_s word;
    scan_op(SCU_OP_READ, addr, 4'h0);
    shift_dr('0, 1'b0, word);
    data = word.data;
endtask

`endif

// ==== sim/scu_tb.sv ====
// Simulation top that drives scan accesses and reset inputs into the control unit and checks resets
`timescale 1ns/1ps
`default_nettype none

module scu_tb;

    import scu_pkg::*;

    localparam int unsigned SYNC_STAGES = 3;
    localparam int          SEED        = 17498;
    // Longest any single wait may take
    localparam int          WAIT_LIMIT  = 50;

    typedef enum int {
        OUT_SYS_RST, OUT_CORE_RST, OUT_DM_RST, OUT_HDU_RST,
        OUT_SYS_QLFY, OUT_CORE_QLFY, OUT_HDU_QLFY, OUT_SYS_STS, OUT_CORE_STS
    } out_e;

    logic clk;
    logic pwrup_rst_n_sync;
    logic rst_n_i;
    logic cpu_rst_n_i;
    logic ndm_rst_n_i;
    logic hart_rst_n_i;
    logic ch_sel_i;
    logic ch_id_i;
    logic ch_capture_i;
    logic ch_shift_i;
    logic ch_update_i;
    logic ch_tdi_i;
    logic ch_tdo_o;
    logic sys_rst_n_o;
    logic core_rst_n_o;
    logic dm_rst_n_o;
    logic hdu_rst_n_o;
    logic sys_rst_status_o;
    logic core_rst_status_o;
    logic sys_rdc_qlfy_o;
    logic core_rdc_qlfy_o;
    logic hdu_rdc_qlfy_o;

    int        err_cnt;
    int        check_cnt;
    int        timeout_cnt;
    int        qcyc;
    int        rcyc;
    int        cyc;
    scu_data_t rd;
    scu_data_t rnd;
    // Reference copies of CONTROL and MODE
    scu_data_t exp_ctrl;
    scu_data_t exp_mode;

    `include "scu_tb_tasks.svh"

    always #4 clk = ~clk;

    scu_top #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_dut (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .cpu_rst_n_i       (cpu_rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .ch_sel_i          (ch_sel_i),
        .ch_id_i           (ch_id_i),
        .ch_capture_i      (ch_capture_i),
        .ch_shift_i        (ch_shift_i),
        .ch_update_i       (ch_update_i),
        .ch_tdi_i          (ch_tdi_i),
        .ch_tdo_o          (ch_tdo_o),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu_rdc_qlfy_o    (hdu_rdc_qlfy_o)
    );

    // ------------------------------
    // Qualifier ordering
    // ------------------------------

    // Reset falls only when its qualifier fell exactly one sample before
    sys_qlfy_order: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(sys_rst_n_o) |-> (!$past(sys_rdc_qlfy_o) && $past(sys_rdc_qlfy_o, 2)))
        else begin
            err_cnt++;
            $display("Sys qualifier did not fall one cycle before sys reset at %0t", $time);
        end

    core_qlfy_order: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(core_rst_n_o) |-> (!$past(core_rdc_qlfy_o) && $past(core_rdc_qlfy_o, 2)))
        else begin
            err_cnt++;
            $display("Core qualifier did not fall one cycle before core reset at %0t", $time);
        end

    hdu_qlfy_order: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        $fell(hdu_rst_n_o) |-> (!$past(hdu_rdc_qlfy_o) && $past(hdu_rdc_qlfy_o, 2)))
        else begin
            err_cnt++;
            $display("HDU qualifier did not fall one cycle before HDU reset at %0t", $time);
        end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        clk              = 1'b0;
        pwrup_rst_n_sync = 1'b0;
        // External resets idle high
        rst_n_i          = 1'b1;
        cpu_rst_n_i      = 1'b1;
        ndm_rst_n_i      = 1'b1;
        hart_rst_n_i     = 1'b1;
        ch_sel_i         = 1'b1;
        ch_id_i          = 1'b0;
        ch_capture_i     = 1'b0;
        ch_shift_i       = 1'b0;
        ch_update_i      = 1'b0;
        ch_tdi_i         = 1'b0;
        err_cnt          = 0;
        check_cnt        = 0;
        timeout_cnt      = 0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        #1;
        pwrup_rst_n_sync = 1'b1;

        // Release and reset values
        wait_level(OUT_SYS_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_DM_RST, 1'b1, WAIT_LIMIT, cyc);
        check_bit("release_sys", 1'b1, sys_rst_n_o);
        check_bit("release_core", 1'b1, core_rst_n_o);
        scan_read(SCU_ADDR_CONTROL, rd);
        check_data("reset_control", 4'h0, rd);
        scan_read(SCU_ADDR_MODE, rd);
        check_data("reset_mode", 4'h0, rd);
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("reset_sticky", 4'h0, rd);

        // Register access with random data
        exp_ctrl = scu_data_t'($urandom());
        scan_op(SCU_OP_WRITE, SCU_ADDR_CONTROL, exp_ctrl);
        scan_read(SCU_ADDR_CONTROL, rd);
        check_data("write_control", exp_ctrl, rd);
        exp_mode = scu_data_t'($urandom());
        scan_op(SCU_OP_WRITE, SCU_ADDR_MODE, exp_mode);
        scan_read(SCU_ADDR_MODE, rd);
        check_data("write_mode", exp_mode, rd);
        rnd      = scu_data_t'($urandom());
        exp_ctrl = exp_ctrl | rnd;
        scan_op(SCU_OP_SETBITS, SCU_ADDR_CONTROL, rnd);
        scan_read(SCU_ADDR_CONTROL, rd);
        check_data("setbits_control", exp_ctrl, rd);
        rnd      = scu_data_t'($urandom());
        exp_ctrl = exp_ctrl & ~rnd;
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_CONTROL, rnd);
        scan_read(SCU_ADDR_CONTROL, rd);
        check_data("clrbits_control", exp_ctrl, rd);
        rnd      = scu_data_t'($urandom());
        exp_mode = exp_mode | rnd;
        scan_op(SCU_OP_SETBITS, SCU_ADDR_MODE, rnd);
        scan_read(SCU_ADDR_MODE, rd);
        check_data("setbits_mode", exp_mode, rd);
        rnd      = scu_data_t'($urandom());
        exp_mode = exp_mode & ~rnd;
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_MODE, rnd);
        scan_read(SCU_ADDR_MODE, rd);
        check_data("clrbits_mode", exp_mode, rd);
        // Back to idle
        scan_op(SCU_OP_WRITE, SCU_ADDR_CONTROL, 4'h0);
        scan_op(SCU_OP_WRITE, SCU_ADDR_MODE, 4'h0);
        wait_level(OUT_SYS_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_DM_RST, 1'b1, WAIT_LIMIT, cyc);

        // Software system reset
        // Update edge counts as the first clock
        scan_op(SCU_OP_SETBITS, SCU_ADDR_CONTROL, 4'b0001);
        wait_level(OUT_SYS_QLFY, 1'b0, WAIT_LIMIT, qcyc);
        wait_level(OUT_SYS_RST, 1'b0, WAIT_LIMIT, rcyc);
        check_count("sysrst_latency", 3, 1 + qcyc + rcyc);
        check_count("sysrst_qlfy_lead", 1, rcyc);
        check_bit("sysrst_core", 1'b0, core_rst_n_o);
        check_bit("sysrst_core_qlfy", 1'b0, core_rdc_qlfy_o);
        // DM untouched while dm_rst_bhv is clear
        check_bit("sysrst_dm_kept", 1'b1, dm_rst_n_o);
        wait_level(OUT_SYS_STS, 1'b1, WAIT_LIMIT, cyc);
        check_count("sysrst_status_lag", int'(SYNC_STAGES), cyc);
        check_bit("sysrst_core_status", 1'b1, core_rst_status_o);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_CONTROL, 4'b0001);
        wait_level(OUT_SYS_RST, 1'b1, WAIT_LIMIT, rcyc);
        wait_level(OUT_SYS_QLFY, 1'b1, WAIT_LIMIT, qcyc);
        check_count("sysrel_latency", 2, 1 + rcyc);
        check_count("sysrel_qlfy_lag", 1, qcyc);
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        check_bit("sysrel_core", 1'b1, core_rst_n_o);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_SYS_STS, 1'b0, WAIT_LIMIT, cyc);

        // Core and HDU from hart reset input
        hart_rst_n_i = 1'b0;
        wait_level(OUT_CORE_RST, 1'b0, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_RST, 1'b0, WAIT_LIMIT, cyc);
        check_bit("hart_sys_kept", 1'b1, sys_rst_n_o);
        // Core status on its own, sys status stays clear
        wait_level(OUT_CORE_STS, 1'b1, WAIT_LIMIT, cyc);
        check_count("hart_core_status_lag", int'(SYNC_STAGES), cyc);
        check_bit("hart_sys_status_kept", 1'b0, sys_rst_status_o);
        hart_rst_n_i = 1'b1;
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        // HDU kept out of core resets
        scan_op(SCU_OP_SETBITS, SCU_ADDR_MODE, 4'b0010);
        hart_rst_n_i = 1'b0;
        wait_level(OUT_CORE_RST, 1'b0, WAIT_LIMIT, cyc);
        idle(4);
        check_bit("hdu_bhv_rst_kept", 1'b1, hdu_rst_n_o);
        check_bit("hdu_bhv_qlfy_kept", 1'b1, hdu_rdc_qlfy_o);
        hart_rst_n_i = 1'b1;
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_MODE, 4'b0010);

        // DM follows the software system reset when enabled
        scan_op(SCU_OP_SETBITS, SCU_ADDR_MODE, 4'b0001);
        check_bit("dm_bhv_idle", 1'b1, dm_rst_n_o);
        scan_op(SCU_OP_SETBITS, SCU_ADDR_CONTROL, 4'b0001);
        wait_level(OUT_DM_RST, 1'b0, WAIT_LIMIT, cyc);
        check_count("dm_assert_lag", 1, cyc);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_CONTROL, 4'b0001);
        wait_level(OUT_DM_RST, 1'b1, WAIT_LIMIT, cyc);
        check_count("dm_release_lag", 1, cyc);
        wait_level(OUT_SYS_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_MODE, 4'b0001);

        // STATUS live bits and STICKY latching
        // Every reset has been asserted by now
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("sticky_all_set", 4'hF, rd);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_STICKY, 4'hF);
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("sticky_clear", 4'h0, rd);
        scan_op(SCU_OP_SETBITS, SCU_ADDR_CONTROL, 4'b0010);
        wait_level(OUT_CORE_RST, 1'b0, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_RST, 1'b0, WAIT_LIMIT, cyc);
        // Core and HDU asserted while sys and DM are not
        scan_read(SCU_ADDR_STATUS, rd);
        check_data("status_live", 4'b1010, rd);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_CONTROL, 4'b0010);
        wait_level(OUT_CORE_QLFY, 1'b1, WAIT_LIMIT, cyc);
        wait_level(OUT_HDU_QLFY, 1'b1, WAIT_LIMIT, cyc);
        scan_read(SCU_ADDR_STATUS, rd);
        check_data("status_released", 4'h0, rd);
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("sticky_latched", 4'b1010, rd);
        scan_op(SCU_OP_WRITE, SCU_ADDR_STICKY, 4'h0);
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("sticky_write_ignored", 4'b1010, rd);
        scan_op(SCU_OP_WRITE, SCU_ADDR_STATUS, 4'hF);
        scan_read(SCU_ADDR_STATUS, rd);
        check_data("status_write_ignored", 4'h0, rd);
        scan_op(SCU_OP_CLRBITS, SCU_ADDR_STICKY, 4'b0010);
        scan_read(SCU_ADDR_STICKY, rd);
        check_data("sticky_clrbits", 4'b1000, rd);

        // Deselected chain
        // Wrong id first, then no select
        ch_id_i = 1'b1;
        scan_op(SCU_OP_WRITE, SCU_ADDR_CONTROL, 4'b0011);
        scan_op(SCU_OP_WRITE, SCU_ADDR_MODE, 4'b0011);
        ch_id_i  = 1'b0;
        ch_sel_i = 1'b0;
        scan_op(SCU_OP_WRITE, SCU_ADDR_CONTROL, 4'b0011);
        ch_sel_i = 1'b1;
        scan_read(SCU_ADDR_CONTROL, rd);
        check_data("desel_control", 4'h0, rd);
        scan_read(SCU_ADDR_MODE, rd);
        check_data("desel_mode", 4'h0, rd);
        check_bit("desel_sys", 1'b1, sys_rst_n_o);
        check_bit("desel_core", 1'b1, core_rst_n_o);
        check_bit("desel_dm", 1'b1, dm_rst_n_o);
        check_bit("desel_hdu", 1'b1, hdu_rst_n_o);

        $display("Summary: %0d checks, %0d errors, %0d timeouts", check_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : scu_tb

`default_nettype wire
